// File: list.f
+incdir+source
+incdir+dv
source/exu_pkg.sv
source/lsu_pkg.sv
source/alu.sv
source/mul.sv
source/div.sv
source/mem_req.sv
source/ex_stage.sv
dv/clk_gen.sv
dv/ex_tb.sv

// File: dv/ex_ref.svh
`ifndef EX_REF_SVH
`define EX_REF_SVH

`include "ex_params.svh"

function automatic logic [`EX_XLEN-1:0] alu_ref(
    input exu_pkg::alu_op_e    op,
    input logic [`EX_XLEN-1:0] a,
    input logic [`EX_XLEN-1:0] b
);
    logic signed [`EX_XLEN-1:0] sa;
    sa = a;
    case (op)
        exu_pkg::ALU_ADD:  return a + b;
        exu_pkg::ALU_SUB:  return a - b;
        exu_pkg::ALU_SLT:  return (sa < $signed(b)) ? 1 : 0;
        exu_pkg::ALU_SLTU: return (a < b) ? 1 : 0;
        exu_pkg::ALU_AND:  return a & b;
        exu_pkg::ALU_OR:   return a | b;
        exu_pkg::ALU_NOR:  return ~(a | b);
        exu_pkg::ALU_XOR:  return a ^ b;
        exu_pkg::ALU_SLL:  return a << b[4:0];
        exu_pkg::ALU_SRL:  return a >> b[4:0];
        exu_pkg::ALU_SRA:  return sa >>> b[4:0];
        exu_pkg::ALU_LUI:  return b;
        default:           return '0;
    endcase
endfunction

function automatic logic is_div_op(input exu_pkg::md_op_e op);
    return (op == exu_pkg::MD_DIV) || (op == exu_pkg::MD_DIV_U) ||
           (op == exu_pkg::MD_MOD) || (op == exu_pkg::MD_MOD_U);
endfunction

// truncating division with the remainder taking the dividend's sign
function automatic logic [`EX_XLEN-1:0] div_ref(
    input exu_pkg::md_op_e     op,
    input logic [`EX_XLEN-1:0] x,
    input logic [`EX_XLEN-1:0] y
);
    longint              sx;
    longint              sy;
    logic [`EX_XLEN-1:0] q;
    logic [`EX_XLEN-1:0] r;
    sx = longint'($signed(x));
    sy = longint'($signed(y));
    if (y == '0) begin
        q = '1;
        r = x;
    end else if ((op == exu_pkg::MD_DIV) || (op == exu_pkg::MD_MOD)) begin
        q = `EX_XLEN'(sx / sy);
        r = `EX_XLEN'(sx % sy);
    end else begin
        q = x / y;
        r = x % y;
    end
    return ((op == exu_pkg::MD_MOD) || (op == exu_pkg::MD_MOD_U)) ? r : q;
endfunction

function automatic logic [2*`EX_XLEN-1:0] mul_ref(
    input exu_pkg::md_op_e     op,
    input logic [`EX_XLEN-1:0] x,
    input logic [`EX_XLEN-1:0] y
);
    longint sx;
    longint sy;
    sx = longint'($signed(x));
    sy = longint'($signed(y));
    if (op == exu_pkg::MD_MUL_HI_U)
        return {{`EX_XLEN{1'b0}}, x} * {{`EX_XLEN{1'b0}}, y};
    return sx * sy;
endfunction

function automatic lsu_pkg::mem_size_e size_of(input lsu_pkg::mem_op_e op);
    case (op)
        lsu_pkg::LD_H, lsu_pkg::LD_HU, lsu_pkg::ST_H: return lsu_pkg::SIZE_HALF;
        lsu_pkg::LD_W, lsu_pkg::ST_W:                 return lsu_pkg::SIZE_WORD;
        default:                                      return lsu_pkg::SIZE_BYTE;
    endcase
endfunction

function automatic logic is_store_op(input lsu_pkg::mem_op_e op);
    return (op == lsu_pkg::ST_B) || (op == lsu_pkg::ST_H) || (op == lsu_pkg::ST_W);
endfunction

function automatic logic misaligned(input lsu_pkg::mem_op_e op, input logic [1:0] low);
    if (size_of(op) == lsu_pkg::SIZE_HALF)
        return low[0];
    if (size_of(op) == lsu_pkg::SIZE_WORD)
        return low != 2'b00;
    return 1'b0;
endfunction

// lanes from the first addressed byte up to the access width
function automatic logic [3:0] lanes_of(input lsu_pkg::mem_op_e op, input logic [1:0] low);
    int         bytes;
    int         i;
    logic [3:0] s;
    bytes = (size_of(op) == lsu_pkg::SIZE_WORD) ? 4 :
            (size_of(op) == lsu_pkg::SIZE_HALF) ? 2 : 1;
    s = 4'b0000;
    for (i = 0; i < 4; i++)
        if (is_store_op(op) && (i >= low) && (i < low + bytes))
            s[i] = 1'b1;
    return s;
endfunction

function automatic logic [`EX_XLEN-1:0] store_data_of(
    input lsu_pkg::mem_op_e    op,
    input logic [`EX_XLEN-1:0] rkd
);
    case (size_of(op))
        lsu_pkg::SIZE_BYTE: return {4{rkd[7:0]}};
        lsu_pkg::SIZE_HALF: return {2{rkd[15:0]}};
        default:            return rkd;
    endcase
endfunction

`endif

// File: dv/ex_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "ex_params.svh"

module ex_tb;

    `include "ex_ref.svh"

    typedef struct {
        exu_pkg::alu_op_e       alu_op;
        exu_pkg::md_op_e        md_op;
        lsu_pkg::mem_op_e       mem_op;
        logic [`EX_XLEN-1:0]    src1;
        logic [`EX_XLEN-1:0]    src2;
        logic [`EX_XLEN-1:0]    rkd;
        logic                   rf_we;
        logic [`EX_RADDR_W-1:0] rf_waddr;
        logic [`EX_XLEN-1:0]    pc;
    } item_t;

    logic                   clk;
    logic                   resetn;
    logic                   in_valid;
    exu_pkg::alu_op_e       in_alu_op;
    logic [`EX_XLEN-1:0]    in_src1;
    logic [`EX_XLEN-1:0]    in_src2;
    logic [`EX_XLEN-1:0]    in_rkd;
    exu_pkg::md_op_e        in_md_op;
    lsu_pkg::mem_op_e       in_mem_op;
    logic                   in_rf_we;
    logic [`EX_RADDR_W-1:0] in_rf_waddr;
    logic [`EX_XLEN-1:0]    in_pc;
    logic                   ex_allowin;
    logic                   out_valid;
    logic [`EX_XLEN-1:0]    out_result;
    logic                   out_rf_we;
    logic [`EX_RADDR_W-1:0] out_rf_waddr;
    logic [`EX_XLEN-1:0]    out_pc;
    lsu_pkg::mem_op_e       out_mem_op;
    exu_pkg::md_op_e        out_md_op;
    logic                   out_ale;
    logic                   mem_allowin;
    logic [2*`EX_XLEN-1:0]  mul_product;
    logic                   data_sram_req;
    logic                   data_sram_wr;
    lsu_pkg::mem_size_e     data_sram_size;
    logic [3:0]             data_sram_wstrb;
    logic [`EX_XLEN-1:0]    data_sram_addr;
    logic [`EX_XLEN-1:0]    data_sram_wdata;
    logic                   data_sram_addr_ok;
    logic                   ex_flush;

    integer                 seed = 6369;
    integer                 mock_seed = 6369;
    int                     errors = 0;
    int                     timeouts = 0;
    int                     req_count = 0;
    logic                   sram_hold = 1'b0;
    logic                   mul_pending = 1'b0;
    logic [2*`EX_XLEN-1:0]  mul_exp;
    logic [`EX_XLEN-1:0]    next_pc = 32'h1c00_0000;
    string                  test_name = "reset";
    item_t                  exp_q[$];

    clk_gen u_clk (.clk(clk));

    ex_stage u_dut (.*);

    task automatic end_run();
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    task automatic timed_out(input string what);
        timeouts++;
        $display("[%s] timeout, %s did not happen in time", test_name, what);
        end_run();
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
        assert (got === exp) else begin
            errors++;
            $display("** Error in %s, %s: expected %h, actual %h", test_name, name, exp, got);
        end
    endtask

    task automatic check_request();
        item_t               head;
        logic [`EX_XLEN-1:0] addr;
        assert (exp_q.size() > 0) else begin
            errors++;
            $display("[%s] sram request accepted with no item in the stage", test_name);
        end
        if (exp_q.size() > 0) begin
            head = exp_q[0];
            addr = alu_ref(head.alu_op, head.src1, head.src2);
            check_value("data_sram_wr", is_store_op(head.mem_op), data_sram_wr);
            check_value("data_sram_size", size_of(head.mem_op), data_sram_size);
            check_value("data_sram_addr", addr, data_sram_addr);
            check_value("data_sram_wstrb", lanes_of(head.mem_op, addr[1:0]),
                        data_sram_wstrb);
            if (is_store_op(head.mem_op))
                check_value("data_sram_wdata", store_data_of(head.mem_op, head.rkd),
                            data_sram_wdata);
        end
    endtask

    task automatic check_leaving();
        item_t               head;
        logic [`EX_XLEN-1:0] addr;
        logic                ale;
        assert (exp_q.size() > 0) else begin
            errors++;
            $display("[%s] an item left the stage that was never issued", test_name);
        end
        if (exp_q.size() > 0) begin
            head = exp_q.pop_front();
            addr = alu_ref(head.alu_op, head.src1, head.src2);
            ale  = misaligned(head.mem_op, addr[1:0]);
            check_value("out_result", is_div_op(head.md_op) ?
                        div_ref(head.md_op, head.src1, head.src2) : addr, out_result);
            check_value("out_rf_we", head.rf_we, out_rf_we);
            check_value("out_rf_waddr", head.rf_waddr, out_rf_waddr);
            check_value("out_pc", head.pc, out_pc);
            check_value("out_mem_op", head.mem_op, out_mem_op);
            check_value("out_md_op", head.md_op, out_md_op);
            check_value("out_ale", ale, out_ale);
            check_value("request count",
                        ((head.mem_op != lsu_pkg::MEM_NONE) && !ale) ? 1 : 0, req_count);
            req_count = 0;
            if ((head.md_op == exu_pkg::MD_MUL_LO) || (head.md_op == exu_pkg::MD_MUL_HI) ||
                (head.md_op == exu_pkg::MD_MUL_HI_U)) begin
                mul_pending = 1'b1;
                mul_exp     = mul_ref(head.md_op, head.src1, head.src2);
            end
        end
    endtask

    // kind 0 alu, 1 multiply, 2 divide, 3 load or store
    task automatic build_item(input int kind, output item_t it);
        int pick;
        it.pc       = next_pc;
        next_pc     = next_pc + 4;
        it.src1     = $random(seed);
        it.src2     = $random(seed);
        it.rkd      = $random(seed);
        it.rf_we    = $random(seed);
        it.rf_waddr = $random(seed);
        it.alu_op   = exu_pkg::alu_op_e'({$random(seed)} % 12);
        it.md_op    = exu_pkg::MD_NONE;
        it.mem_op   = lsu_pkg::MEM_NONE;
        case (kind)
            1: it.md_op = exu_pkg::md_op_e'(1 + {$random(seed)} % 3);
            2: begin
                it.md_op = exu_pkg::md_op_e'(4 + {$random(seed)} % 4);
                pick = {$random(seed)} % 6;
                if (pick == 0)
                    it.src2 = '0;
                else if (pick == 1) begin
                    it.src1 = 32'h8000_0000;
                    it.src2 = 32'hffff_ffff;
                end else if (pick == 2)
                    it.src2 = {$random(seed)} % 8;
            end
            3: begin
                it.mem_op = lsu_pkg::mem_op_e'(1 + {$random(seed)} % 8);
                it.alu_op = exu_pkg::ALU_ADD;
                it.src2   = {$random(seed)} % 64;
            end
            default: ;
        endcase
    endtask

    // called right after a falling edge, returns on one
    task automatic issue_item(input item_t it);
        int waited;
        waited      = 0;
        in_valid    = 1'b1;
        in_alu_op   = it.alu_op;
        in_md_op    = it.md_op;
        in_mem_op   = it.mem_op;
        in_src1     = it.src1;
        in_src2     = it.src2;
        in_rkd      = it.rkd;
        in_rf_we    = it.rf_we;
        in_rf_waddr = it.rf_waddr;
        in_pc       = it.pc;
        #10;
        while (!ex_allowin && waited < 200) begin
            waited++;
            @(negedge clk);
            #10;
        end
        if (!ex_allowin) begin
            timed_out("ex_allowin for a new item");
        end else begin
            exp_q.push_back(it);
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 1000) begin
            waited++;
            @(negedge clk);
        end
        if (exp_q.size() != 0)
            timed_out("the stage to drain");
    endtask

    // kills the single item in the stage
    task automatic flush_item();
        ex_flush = 1'b1;
        in_valid = 1'b0;
        assert (exp_q.size() == 1) else begin
            errors++;
            $display("[%s] %0d items in the stage at flush, one expected", test_name,
                     exp_q.size());
        end
        if (exp_q.size() > 0)
            void'(exp_q.pop_front());
        req_count = 0;
        repeat (2) @(negedge clk);
        ex_flush = 1'b0;
    endtask

    // mock sram and memory stage
    always @(negedge clk) begin
        data_sram_addr_ok <= !sram_hold && (({$random(mock_seed)} % 3) == 0);
        mem_allowin       <= (({$random(mock_seed)} % 4) != 0);
    end

    // sample just after the inputs settle, ahead of the rising edge
    initial begin
        forever begin
            @(negedge clk);
            #10;
            if (resetn) begin
                if (ex_flush) begin
                    assert (!out_valid && !data_sram_req) else begin
                        errors++;
                        $display("[%s] output or sram request raised during flush", test_name);
                    end
                end
                if (mul_pending) begin
                    check_value("mul_product", mul_exp, mul_product);
                    mul_pending = 1'b0;
                end
                if (data_sram_req && data_sram_addr_ok) begin
                    check_request();
                    req_count++;
                end
                if (out_valid && mem_allowin)
                    check_leaving();
            end
        end
    end

    initial begin
        item_t it;
        int    gap;
        resetn            = 1'b0;
        in_valid          = 1'b0;
        in_alu_op         = exu_pkg::ALU_ADD;
        in_md_op          = exu_pkg::MD_NONE;
        in_mem_op         = lsu_pkg::MEM_NONE;
        in_src1           = '0;
        in_src2           = '0;
        in_rkd            = '0;
        in_rf_we          = 1'b0;
        in_rf_waddr       = '0;
        in_pc             = '0;
        mem_allowin       = 1'b1;
        data_sram_addr_ok = 1'b0;
        ex_flush          = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        #10;
        check_value("ex_allowin", 1, ex_allowin);
        check_value("out_valid", 0, out_valid);
        check_value("data_sram_req", 0, data_sram_req);
        @(negedge clk);

        test_name = "random mix";
        repeat (400) begin
            build_item({$random(seed)} % 4, it);
            issue_item(it);
            gap = {$random(seed)} % 3;
            repeat (gap) @(negedge clk);
        end
        wait_drain();

        test_name = "flush divide";
        build_item(2, it);
        issue_item(it);
        repeat (4) @(negedge clk);
        flush_item();
        repeat (3) begin
            build_item({$random(seed)} % 4, it);
            issue_item(it);
        end
        wait_drain();

        // aligned word load left waiting on addr_ok
        test_name = "flush request";
        sram_hold = 1'b1;
        @(negedge clk);
        build_item(3, it);
        it.mem_op = lsu_pkg::LD_W;
        it.src1   = it.src1 & ~32'h3;
        it.src2   = 32'h8;
        issue_item(it);
        repeat (4) @(negedge clk);
        flush_item();
        sram_hold = 1'b0;
        repeat (3) begin
            build_item({$random(seed)} % 4, it);
            issue_item(it);
        end
        wait_drain();

        repeat (2) @(negedge clk);
        end_run();
    end

endmodule

`default_nettype wire

// File: dv/clk_gen.sv
`default_nettype none
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    // first rising edge comes half a period in
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: source/ex_stage.sv
`default_nettype none
`timescale 1ns/1ps

`include "ex_params.svh"

module ex_stage (
    input  wire                     clk,
    input  wire                     resetn,
    // from decode
    input  wire                     in_valid,
    input  wire exu_pkg::alu_op_e   in_alu_op,
    input  wire [`EX_XLEN-1:0]      in_src1,
    input  wire [`EX_XLEN-1:0]      in_src2,
    input  wire [`EX_XLEN-1:0]      in_rkd,
    input  wire exu_pkg::md_op_e    in_md_op,
    input  wire lsu_pkg::mem_op_e   in_mem_op,
    input  wire                     in_rf_we,
    input  wire [`EX_RADDR_W-1:0]   in_rf_waddr,
    input  wire [`EX_XLEN-1:0]      in_pc,
    output logic                    ex_allowin,
    // to memory stage
    output logic                    out_valid,
    output logic [`EX_XLEN-1:0]     out_result,
    output logic                    out_rf_we,
    output logic [`EX_RADDR_W-1:0]  out_rf_waddr,
    output logic [`EX_XLEN-1:0]     out_pc,
    output lsu_pkg::mem_op_e        out_mem_op,
    output exu_pkg::md_op_e         out_md_op,
    output logic                    out_ale,
    input  wire                     mem_allowin,
    output logic [2*`EX_XLEN-1:0]   mul_product,
    // data sram request side
    output logic                    data_sram_req,
    output logic                    data_sram_wr,
    output lsu_pkg::mem_size_e      data_sram_size,
    output logic [3:0]              data_sram_wstrb,
    output logic [`EX_XLEN-1:0]     data_sram_addr,
    output logic [`EX_XLEN-1:0]     data_sram_wdata,
    input  wire                     data_sram_addr_ok,
    input  wire                     ex_flush
);

    logic                   ex_valid;
    logic                   ready;
    logic                   is_div;
    logic                   is_mod;
    logic                   is_mem;
    logic                   div_done;
    logic                   div_start;
    logic                   div_complete;
    logic                   mem_ale;
    logic [`EX_XLEN-1:0]    alu_result;
    logic [`EX_XLEN-1:0]    div_quotient;
    logic [`EX_XLEN-1:0]    div_remainder;

    exu_pkg::alu_op_e       alu_op_q;
    exu_pkg::md_op_e        md_op_q;
    lsu_pkg::mem_op_e       mem_op_q;
    logic [`EX_XLEN-1:0]    src1_q;
    logic [`EX_XLEN-1:0]    src2_q;
    logic [`EX_XLEN-1:0]    rkd_q;
    logic                   rf_we_q;
    logic [`EX_RADDR_W-1:0] rf_waddr_q;
    logic [`EX_XLEN-1:0]    pc_q;

    always_ff @(posedge clk) begin
        if (!resetn)
            ex_valid <= 1'b0;
        else if (ex_allowin)
            ex_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid && ex_allowin) begin
            alu_op_q   <= in_alu_op;
            md_op_q    <= in_md_op;
            mem_op_q   <= in_mem_op;
            src1_q     <= in_src1;
            src2_q     <= in_src2;
            rkd_q      <= in_rkd;
            rf_we_q    <= in_rf_we;
            rf_waddr_q <= in_rf_waddr;
            pc_q       <= in_pc;
        end
    end

    assign is_div = (md_op_q == exu_pkg::MD_DIV) || (md_op_q == exu_pkg::MD_DIV_U) ||
                    (md_op_q == exu_pkg::MD_MOD) || (md_op_q == exu_pkg::MD_MOD_U);
    assign is_mod = (md_op_q == exu_pkg::MD_MOD) || (md_op_q == exu_pkg::MD_MOD_U);
    assign is_mem = (mem_op_q != lsu_pkg::MEM_NONE);

    // misaligned memory items skip the sram and go at once
    assign ready = (data_sram_req && data_sram_addr_ok) ||
                   (is_div && (div_complete || div_done)) ||
                   !((is_mem && !mem_ale) || is_div);

    assign ex_allowin = !ex_valid || (ready && mem_allowin) || ex_flush;
    assign out_valid  = ex_valid && ready && !ex_flush;

    // remembers a finished divide while memory stage stalls
    always_ff @(posedge clk) begin
        if (!resetn)
            div_done <= 1'b0;
        else if (in_valid && ex_allowin)
            div_done <= 1'b0;
        else if (div_complete)
            div_done <= 1'b1;
    end

    assign div_start = ex_valid && is_div && !div_done;

    alu u_alu (
        .alu_op (alu_op_q),
        .src1   (src1_q),
        .src2   (src2_q),
        .result (alu_result)
    );

    mul u_mul (
        .clk     (clk),
        .resetn  (resetn),
        .md_op   (md_op_q),
        .x       (src1_q),
        .y       (src2_q),
        .product (mul_product)
    );

    div u_div (
        .clk       (clk),
        .resetn    (resetn),
        .abort     (ex_flush),
        .start     (div_start),
        .md_op     (md_op_q),
        .x         (src1_q),
        .y         (src2_q),
        .quotient  (div_quotient),
        .remainder (div_remainder),
        .complete  (div_complete)
    );

    mem_req u_mem_req (
        .mem_op      (mem_op_q),
        .addr        (alu_result),
        .rkd         (rkd_q),
        .item_valid  (ex_valid),
        .mem_allowin (mem_allowin),
        .flush       (ex_flush),
        .sram_req    (data_sram_req),
        .sram_wr     (data_sram_wr),
        .sram_size   (data_sram_size),
        .sram_wstrb  (data_sram_wstrb),
        .sram_wdata  (data_sram_wdata),
        .ale         (mem_ale)
    );

    assign data_sram_addr = alu_result;

    assign out_result   = is_div ? (is_mod ? div_remainder : div_quotient) : alu_result;
    assign out_rf_we    = rf_we_q;
    assign out_rf_waddr = rf_waddr_q;
    assign out_pc       = pc_q;
    assign out_mem_op   = mem_op_q;
    assign out_md_op    = md_op_q;
    assign out_ale      = mem_ale;

    a_out_valid_has_item: assert property (
        @(posedge clk) disable iff (!resetn) out_valid |-> ex_valid
    ) else $error("out_valid raised with an empty stage");

endmodule

`default_nettype wire

// File: source/mem_req.sv
`default_nettype none
`timescale 1ns/1ps

`include "ex_params.svh"

module mem_req (
    input  wire lsu_pkg::mem_op_e  mem_op,
    input  wire [`EX_XLEN-1:0]     addr,
    input  wire [`EX_XLEN-1:0]     rkd,
    input  wire                    item_valid,
    input  wire                    mem_allowin,
    input  wire                    flush,
    output logic                   sram_req,
    output logic                   sram_wr,
    output lsu_pkg::mem_size_e     sram_size,
    output logic [3:0]             sram_wstrb,
    output logic [`EX_XLEN-1:0]    sram_wdata,
    output logic                   ale
);

    logic is_load;
    logic is_store;

    always_comb begin
        is_load   = 1'b0;
        is_store  = 1'b0;
        sram_size = lsu_pkg::SIZE_BYTE;
        case (mem_op)
            lsu_pkg::LD_B, lsu_pkg::LD_BU: is_load = 1'b1;
            lsu_pkg::LD_H, lsu_pkg::LD_HU: begin
                is_load   = 1'b1;
                sram_size = lsu_pkg::SIZE_HALF;
            end
            lsu_pkg::LD_W: begin
                is_load   = 1'b1;
                sram_size = lsu_pkg::SIZE_WORD;
            end
            lsu_pkg::ST_B: is_store = 1'b1;
            lsu_pkg::ST_H: begin
                is_store  = 1'b1;
                sram_size = lsu_pkg::SIZE_HALF;
            end
            lsu_pkg::ST_W: begin
                is_store  = 1'b1;
                sram_size = lsu_pkg::SIZE_WORD;
            end
            default: ;
        endcase
    end

    assign ale = ((sram_size == lsu_pkg::SIZE_HALF) && addr[0]) ||
                 ((sram_size == lsu_pkg::SIZE_WORD) && (addr[1:0] != 2'b00));

    // loads drive no byte lanes
    always_comb begin
        sram_wstrb = 4'b0000;
        if (is_store) begin
            case (sram_size)
                lsu_pkg::SIZE_BYTE: sram_wstrb = 4'b0001 << addr[1:0];
                lsu_pkg::SIZE_HALF: sram_wstrb = addr[1] ? 4'b1100 : 4'b0011;
                default:            sram_wstrb = 4'b1111;
            endcase
        end
    end

    assign sram_wdata = (sram_size == lsu_pkg::SIZE_BYTE) ? {4{rkd[7:0]}} :
                        (sram_size == lsu_pkg::SIZE_HALF) ? {2{rkd[15:0]}} :
                        rkd;

    assign sram_wr  = is_store;
    assign sram_req = (is_load || is_store) && !ale && item_valid && mem_allowin && !flush;

endmodule

`default_nettype wire

// File: source/div.sv
`default_nettype none
`timescale 1ns/1ps

`include "ex_params.svh"

module div (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire                  abort,
    input  wire                  start,
    input  wire exu_pkg::md_op_e md_op,
    input  wire [`EX_XLEN-1:0]   x,
    input  wire [`EX_XLEN-1:0]   y,
    output logic [`EX_XLEN-1:0]  quotient,
    output logic [`EX_XLEN-1:0]  remainder,
    output logic                 complete
);

    localparam int MSB = `EX_XLEN - 1;
    localparam int CW  = $clog2(`EX_DIV_STEPS);
    localparam logic [CW-1:0] LAST_STEP = CW'(`EX_DIV_STEPS - 1);

    logic                busy;
    logic [CW-1:0]       step;
    logic                launch;
    logic                op_signed;
    logic                x_neg;
    logic                y_neg;
    logic [`EX_XLEN-1:0] x_abs;
    logic [`EX_XLEN-1:0] y_abs;
    logic [`EX_XLEN-1:0] divisor;
    logic [`EX_XLEN-1:0] quo;
    logic [`EX_XLEN-1:0] rem;
    logic                q_neg;
    logic                r_neg;
    logic [`EX_XLEN:0]   shifted;
    logic [`EX_XLEN:0]   diff;

    assign op_signed = (md_op == exu_pkg::MD_DIV) || (md_op == exu_pkg::MD_MOD);
    assign x_neg     = op_signed & x[MSB];
    assign y_neg     = op_signed & y[MSB];
    assign x_abs     = x_neg ? -x : x;
    assign y_abs     = y_neg ? -y : y;

    // idle also excludes the complete cycle, so a held start does not relaunch
    assign launch = start && !busy && !complete && !abort;

    always_ff @(posedge clk) begin
        if (!resetn || abort) begin
            busy     <= 1'b0;
            step     <= '0;
            complete <= 1'b0;
        end else begin
            complete <= busy && (step == LAST_STEP);
            if (launch) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == LAST_STEP)
                    busy <= 1'b0;
            end
        end
    end

    // each restoring step shifts in the next dividend bit and tries the subtract
    assign shifted = {rem, quo[MSB]};
    assign diff    = shifted - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (launch) begin
            quo     <= x_abs;
            rem     <= '0;
            divisor <= y_abs;
            // zero divisor keeps the all-ones quotient unsigned
            q_neg   <= (x_neg ^ y_neg) && (y != '0);
            r_neg   <= x_neg;
        end else if (busy) begin
            if (!diff[`EX_XLEN]) begin
                rem <= diff[MSB:0];
                quo <= {quo[MSB-1:0], 1'b1};
            end else begin
                rem <= shifted[MSB:0];
                quo <= {quo[MSB-1:0], 1'b0};
            end
        end
    end

    assign quotient  = q_neg ? -quo : quo;
    assign remainder = r_neg ? -rem : rem;

    a_complete_one_cycle: assert property (
        @(posedge clk) disable iff (!resetn) complete |=> !complete
    ) else $error("divider complete held for two cycles");

endmodule

`default_nettype wire

// File: source/mul.sv
`default_nettype none
`timescale 1ns/1ps

`include "ex_params.svh"

module mul (
    input  wire                    clk,
    input  wire                    resetn,
    input  wire exu_pkg::md_op_e   md_op,
    input  wire [`EX_XLEN-1:0]     x,
    input  wire [`EX_XLEN-1:0]     y,
    output logic [2*`EX_XLEN-1:0]  product
);

    localparam int HALF = `EX_XLEN / 2;
    localparam int MSB  = `EX_XLEN - 1;
    localparam int PPW  = `EX_XLEN + HALF + 2;

    logic                     op_signed;
    logic signed [`EX_XLEN:0] x_ext;
    logic signed [`EX_XLEN:0] y_ext;
    logic signed [HALF:0]     y_lo;
    logic signed [HALF:0]     y_hi;
    logic signed [PPW-1:0]    pp_lo;
    logic signed [PPW-1:0]    pp_hi;

    // the low word does not depend on signedness so only mulh.wu is unsigned
    assign op_signed = (md_op != exu_pkg::MD_MUL_HI_U);
    assign x_ext     = {op_signed & x[MSB], x};
    assign y_ext     = {op_signed & y[MSB], y};

    // y split into an unsigned low half and a signed high half
    assign y_lo = {1'b0, y_ext[HALF-1:0]};
    assign y_hi = y_ext[`EX_XLEN:HALF];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pp_lo <= '0;
            pp_hi <= '0;
        end else begin
            pp_lo <= x_ext * y_lo;
            pp_hi <= x_ext * y_hi;
        end
    end

    // second stage adds the halves in the memory stage cycle
    assign product = pp_lo + (pp_hi <<< HALF);

endmodule

`default_nettype wire

// File: source/alu.sv
`default_nettype none
`timescale 1ns/1ps

`include "ex_params.svh"

module alu (
    input  wire exu_pkg::alu_op_e alu_op,
    input  wire [`EX_XLEN-1:0]    src1,
    input  wire [`EX_XLEN-1:0]    src2,
    output logic [`EX_XLEN-1:0]   result
);

    localparam int SHW = $clog2(`EX_XLEN);
    localparam int MSB = `EX_XLEN - 1;

    logic                sub_mode;
    logic [`EX_XLEN-1:0] add_b;
    logic [`EX_XLEN:0]   add_sum;
    logic                slt_res;
    logic                sltu_res;
    logic [SHW-1:0]      shamt;
    logic [`EX_XLEN-1:0] sll_res;
    logic [`EX_XLEN-1:0] srl_res;
    logic [`EX_XLEN-1:0] sra_res;

    // one adder serves add, sub and both compares
    assign sub_mode = (alu_op == exu_pkg::ALU_SUB) ||
                      (alu_op == exu_pkg::ALU_SLT) ||
                      (alu_op == exu_pkg::ALU_SLTU);
    assign add_b    = sub_mode ? ~src2 : src2;
    assign add_sum  = {1'b0, src1} + {1'b0, add_b} + {{`EX_XLEN{1'b0}}, sub_mode};

    // no carry out means src1 < src2 unsigned
    assign sltu_res = ~add_sum[`EX_XLEN];
    assign slt_res  = (src1[MSB] & ~src2[MSB]) |
                      (~(src1[MSB] ^ src2[MSB]) & add_sum[MSB]);

    assign shamt   = src2[SHW-1:0];
    assign sll_res = src1 << shamt;
    assign srl_res = src1 >> shamt;
    assign sra_res = $signed(src1) >>> shamt;

    always_comb begin
        case (alu_op)
            exu_pkg::ALU_ADD,
            exu_pkg::ALU_SUB:  result = add_sum[MSB:0];
            exu_pkg::ALU_SLT:  result = {{MSB{1'b0}}, slt_res};
            exu_pkg::ALU_SLTU: result = {{MSB{1'b0}}, sltu_res};
            exu_pkg::ALU_AND:  result = src1 & src2;
            exu_pkg::ALU_OR:   result = src1 | src2;
            exu_pkg::ALU_NOR:  result = ~(src1 | src2);
            exu_pkg::ALU_XOR:  result = src1 ^ src2;
            exu_pkg::ALU_SLL:  result = sll_res;
            exu_pkg::ALU_SRL:  result = srl_res;
            exu_pkg::ALU_SRA:  result = sra_res;
            // upper immediate already placed in src2 by decode
            exu_pkg::ALU_LUI:  result = src2;
            default:           result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // load and store kinds
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        LD_B     = 4'd1,
        LD_BU    = 4'd2,
        LD_H     = 4'd3,
        LD_HU    = 4'd4,
        LD_W     = 4'd5,
        ST_B     = 4'd6,
        ST_H     = 4'd7,
        ST_W     = 4'd8
    } mem_op_e;

    // encoding seen on data_sram_size
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

endpackage

`default_nettype wire

// File: source/exu_pkg.sv
`default_nettype none

package exu_pkg;

    // alu function select
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_NOR  = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_e;

    // multiply and divide kinds
    typedef enum logic [2:0] {
        MD_NONE     = 3'd0,
        MD_MUL_LO   = 3'd1,
        MD_MUL_HI   = 3'd2,
        MD_MUL_HI_U = 3'd3,
        MD_DIV      = 3'd4,
        MD_DIV_U    = 3'd5,
        MD_MOD      = 3'd6,
        MD_MOD_U    = 3'd7
    } md_op_e;

endpackage

`default_nettype wire

// File: source/ex_params.svh
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// datapath word width
`define EX_XLEN 32

// register file address width
`define EX_RADDR_W 5

// one quotient bit per divider step
`define EX_DIV_STEPS 32

`endif
